//--- verilog/panel_pkg.sv
`default_nettype none

package panel_pkg;

  // bus and memory geometry
  localparam int ADDR_W    = 12;
  localparam int WORD_W    = 32;
  localparam int STRB_W    = WORD_W / 8;
  localparam int LANE_W    = $clog2(STRB_W);
  localparam int MEM_WORDS = 1024;
  localparam int WIDX_W    = $clog2(MEM_WORDS);

  // display geometry
  localparam int DIGITS    = 8;
  localparam int NIBBLE_W  = 4;
  localparam int SEG_W     = 7;
  localparam int LED_W     = 16;

  // clock cycles per digit, small so simulation stays short
  localparam int SCAN_DIV  = 4;
  localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

  // zero pad above the address in the record view
  localparam int REC_PAD_W = WORD_W - ADDR_W - LED_W;

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [WORD_W-1:0]          word_t;
  typedef logic [STRB_W-1:0]          strb_t;
  typedef logic [WIDX_W-1:0]          widx_t;
  typedef logic [$clog2(DIGITS)-1:0]  digit_t;
  typedef logic [NIBBLE_W-1:0]        nibble_t;
  typedef logic [SCAN_CNT_W-1:0]      scan_cnt_t;
  typedef logic [DIGITS-1:0]          an_t;
  typedef logic [LED_W-1:0]           led_t;

  // active low, bit 6 is segment a and bit 0 is segment g
  typedef logic [SEG_W-1:0]           seg_t;

  // last completed good APB access
  typedef struct packed {
    addr_t addr;
    word_t data;
  } access_rec_t;

  // everything the board pins need from the scanner
  typedef struct packed {
    an_t  an;
    seg_t seg;
    led_t led;
  } panel_out_t;

endpackage

`default_nettype wire

//--- verilog/mem_apb.sv
`default_nettype none

module mem_apb (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  panel_pkg::addr_t       paddr,
  input  panel_pkg::word_t       pwdata,
  input  panel_pkg::strb_t       pstrb,
  output panel_pkg::word_t       prdata,
  output logic                   pready,
  output logic                   pslverr,
  output panel_pkg::access_rec_t rec
);
  import panel_pkg::*;

  word_t mem [MEM_WORDS];

  widx_t widx;
  logic  misaligned;
  logic  setup_ph;
  logic  access_ph;
  logic  good_access;

  assign widx       = paddr[ADDR_W-1:LANE_W];
  assign misaligned = |paddr[LANE_W-1:0];

  assign setup_ph    = psel && !penable;
  assign access_ph   = psel && penable;
  assign good_access = access_ph && !misaligned;

  // zero wait states
  assign pready = access_ph;

  // read data and error flag are set up during the setup cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      pslverr <= setup_ph && misaligned;
      if (setup_ph && !pwrite) begin
        prdata <= misaligned ? '0 : mem[widx];
      end
    end
  end

  // byte lane writes at the end of the access cycle
  always_ff @(posedge clk) begin
    if (good_access && pwrite) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (pstrb[b]) begin
          mem[widx][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

  // record of the last good access, write data or read data
  always_ff @(posedge clk) begin
    if (reset) begin
      rec <= '0;
    end else if (good_access) begin
      rec.addr <= paddr;
      rec.data <= pwrite ? pwdata : prdata;
    end
  end

  // access phase only ever with select
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (reset)
    penable |-> psel
  );

  // setup is followed by access on the same address
  a_paddr_stable: assert property (
    @(posedge clk) disable iff (reset)
    setup_ph |=> (access_ph && $stable(paddr))
  );

endmodule

`default_nettype wire

//--- verilog/dbg_probe.sv
`default_nettype none

module dbg_probe (
  input  logic             clk,
  input  logic             reset,
  input  logic             debug,
  input  panel_pkg::word_t core_word,
  output panel_pkg::word_t probe_word
);

  // sample the core word every cycle
  // debug freezes the value captured just before it rose
  always_ff @(posedge clk) begin
    if (reset) begin
      probe_word <= '0;
    end else if (!debug) begin
      probe_word <= core_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/panel_mux.sv
`default_nettype none

module panel_mux (
  input  logic                   prog,
  input  panel_pkg::word_t       probe_word,
  input  panel_pkg::access_rec_t rec,
  output panel_pkg::word_t       panel_word
);
  import panel_pkg::*;

  word_t rec_view;

  // record view from the top down is pad, address, low data half
  // so the address lands on digits 4 to 6 and the data on the leds
  assign rec_view = {{REC_PAD_W{1'b0}}, rec.addr, rec.data[LED_W-1:0]};

  always_comb begin
    if (prog) begin
      panel_word = rec_view;
    end else begin
      panel_word = probe_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/seg_scan.sv
`default_nettype none

module seg_scan (
  input  logic                  clk,
  input  logic                  reset,
  input  panel_pkg::word_t      panel_word,
  output panel_pkg::panel_out_t out
);
  import panel_pkg::*;

  scan_cnt_t div_cnt;
  digit_t    digit;
  logic      tick;
  nibble_t   nib;
  seg_t      seg;
  an_t       an_rot;

  assign tick = (div_cnt == scan_cnt_t'(SCAN_DIV - 1));

  // tick divider
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // digit index wraps 7 back to 0 on its own
  always_ff @(posedge clk) begin
    if (reset) begin
      digit <= '0;
    end else if (tick) begin
      digit <= digit + 1'b1;
    end
  end

  // nibble for the lit digit, straight from the current word
  assign nib = panel_word[digit*NIBBLE_W +: NIBBLE_W];

  // hex to segments, active low, a in bit 6
  always_comb begin
    case (nib)
      4'h0:    seg = 7'b0000001;
      4'h1:    seg = 7'b1001111;
      4'h2:    seg = 7'b0010010;
      4'h3:    seg = 7'b0000110;
      4'h4:    seg = 7'b1001100;
      4'h5:    seg = 7'b0100100;
      4'h6:    seg = 7'b0100000;
      4'h7:    seg = 7'b0001111;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0000100;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b1100000;
      4'hc:    seg = 7'b0110001;
      4'hd:    seg = 7'b1000010;
      4'he:    seg = 7'b0110000;
      4'hf:    seg = 7'b0111000;
      default: seg = 7'b1111111;
    endcase
  end

  always_comb begin
    // one anode pulled low
    out.an  = ~(an_t'(1) << digit);
    out.seg = seg;
    out.led = panel_word[LED_W-1:0];
  end

  // anode pattern one digit further up
  assign an_rot = {out.an[DIGITS-2:0], out.an[DIGITS-1]};

  // the low anode moves up one place per tick
  a_an_steps: assert property (
    @(posedge clk) disable iff (reset)
    tick |=> (out.an == $past(an_rot))
  );

  // and stays put between ticks
  a_an_holds: assert property (
    @(posedge clk) disable iff (reset)
    !tick |=> $stable(out.an)
  );

endmodule

`default_nettype wire

//--- verilog/panel_top.sv
`default_nettype none

module panel_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic             debug,
  input  logic             prog,
  input  panel_pkg::addr_t paddr,
  input  panel_pkg::word_t pwdata,
  input  panel_pkg::word_t core_word,
  input  panel_pkg::strb_t pstrb,
  output panel_pkg::word_t prdata,
  output logic             pready,
  output logic             pslverr,
  output panel_pkg::an_t   an,
  output panel_pkg::seg_t  sev_out,
  output panel_pkg::led_t  led
);
  import panel_pkg::*;

  access_rec_t rec;
  word_t       probe_word;
  word_t       panel_word;
  panel_out_t  pout;

  // data memory on APB
  mem_apb u_mem (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rec     (rec)
  );

  // core debug word sampler
  dbg_probe u_probe (
    .clk        (clk),
    .reset      (reset),
    .debug      (debug),
    .core_word  (core_word),
    .probe_word (probe_word)
  );

  // prog selects the memory access view
  panel_mux u_mux (
    .prog       (prog),
    .probe_word (probe_word),
    .rec        (rec),
    .panel_word (panel_word)
  );

  seg_scan u_scan (
    .clk        (clk),
    .reset      (reset),
    .panel_word (panel_word),
    .out        (pout)
  );

  // board pins
  assign an      = pout.an;
  assign sev_out = pout.seg;
  assign led     = pout.led;

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`default_nettype none

module clk_gen (
  output logic clk,
  output logic reset
);

  // 20 unit period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held over the first three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/panel_tb.sv
`default_nettype none

module panel_tb;
  import panel_pkg::*;

  logic  clk;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  logic  debug;
  logic  prog;
  addr_t paddr;
  word_t pwdata;
  word_t core_word;
  strb_t pstrb;
  word_t prdata;
  logic  pready;
  logic  pslverr;
  an_t   an;
  seg_t  sev_out;
  led_t  led;

  logic [31:0] lfsr_state;

  // reference state
  word_t model_mem [MEM_WORDS];
  addr_t rec_addr_m;
  word_t rec_data_m;
  word_t probe_model;

  clk_gen u_clk (
    .clk   (clk),
    .reset (reset)
  );

  panel_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .debug     (debug),
    .prog      (prog),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .core_word (core_word),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .an        (an),
    .sev_out   (sev_out),
    .led       (led)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // lit segments abcdefg, then inverted for the active low pins
  function automatic seg_t seg_decode(input nibble_t n);
    logic [6:0] lit;
    case (n)
      4'h0: lit = 7'h7e;
      4'h1: lit = 7'h30;
      4'h2: lit = 7'h6d;
      4'h3: lit = 7'h79;
      4'h4: lit = 7'h33;
      4'h5: lit = 7'h5b;
      4'h6: lit = 7'h5f;
      4'h7: lit = 7'h70;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h7b;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h1f;
      4'hc: lit = 7'h4e;
      4'hd: lit = 7'h3d;
      4'he: lit = 7'h4f;
      4'hf: lit = 7'h47;
    endcase
    return ~lit;
  endfunction

  function automatic nibble_t nibble_of(input word_t w, input int d);
    return nibble_t'(w >> (NIBBLE_W * d));
  endfunction

  // -1 when no single anode is low
  function automatic int digit_of_an(input an_t a);
    int d;
    d = -1;
    for (int i = 0; i < DIGITS; i++) begin
      if (a == ~(an_t'(1) << i)) begin
        d = i;
      end
    end
    return d;
  endfunction

  task automatic report_fail();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("** Error: %s expected %h got %h", name, exp, act);
      report_fail();
    end
  endtask

  // one APB transfer, response sampled mid access cycle
  task automatic apb_xfer(input logic wr, input addr_t a, input word_t d, input strb_t s,
                          output word_t rd, output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    pstrb   <= s;
    @(negedge clk);
    check_word("pready", word_t'(0), word_t'(pready));
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > 16) begin
        $display("timeout: pready never rose in the access cycle");
        report_fail();
      end
      @(negedge clk);
    end
    // no wait states, so the first access cycle completes
    assert (waited == 0) else begin
      $display("pready was not high in the first access cycle");
      report_fail();
    end
    rd  = prdata;
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // transfer plus checks against the memory and record model
  task automatic mem_access(input logic wr, input addr_t a, input word_t d, input strb_t s);
    word_t rd;
    logic  err;
    widx_t w;
    logic  bad;
    w   = a[ADDR_W-1:LANE_W];
    bad = |a[LANE_W-1:0];
    apb_xfer(wr, a, d, s, rd, err);
    check_word("pslverr", word_t'(bad), word_t'(err));
    if (!wr) begin
      check_word("prdata", bad ? word_t'(0) : model_mem[w], rd);
    end
    if (!bad) begin
      rec_addr_m = a;
      rec_data_m = wr ? d : model_mem[w];
      if (wr) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (s[b]) begin
            model_mem[w][8*b +: 8] = d[8*b +: 8];
          end
        end
      end
    end
  endtask

  task automatic run_memory_mix(input int count);
    logic  wr;
    addr_t a;
    for (int i = 0; i < count; i++) begin
      wr = 1'(rand_bits(1));
      // small window so reads often hit recent writes
      a = {widx_t'(rand_bits(5)), 2'b00};
      mem_access(wr, a, rand_bits(32), strb_t'(rand_bits(4)));
    end
  endtask

  task automatic run_error_cases(input int count);
    widx_t      w;
    logic [1:0] lane;
    @(posedge clk);
    prog <= 1'b1;
    @(negedge clk);
    check_word("led", word_t'(rec_data_m[15:0]), word_t'(led));
    for (int i = 0; i < count; i++) begin
      w    = widx_t'(rand_bits(5));
      lane = 2'(rand_bits(2));
      if (lane == 2'd0) begin
        lane = 2'd2;
      end
      mem_access(1'b1, {w, lane}, rand_bits(32), 4'hf);
      @(negedge clk);
      check_word("led", word_t'(rec_data_m[15:0]), word_t'(led));
      mem_access(1'b0, {w, lane}, word_t'(0), 4'h0);
      @(negedge clk);
      check_word("led", word_t'(rec_data_m[15:0]), word_t'(led));
      // aligned word must still hold its old contents
      mem_access(1'b0, {w, 2'b00}, word_t'(0), 4'h0);
      @(negedge clk);
      check_word("led", word_t'(rec_data_m[15:0]), word_t'(led));
    end
  endtask

  task automatic run_record_view(input int count);
    logic  wr;
    addr_t a;
    int    d;
    nibble_t nib;
    for (int i = 0; i < count; i++) begin
      wr = 1'(rand_bits(1));
      // full address range so every address digit varies
      a  = {widx_t'(rand_bits(WIDX_W)), 2'b00};
      mem_access(wr, a, rand_bits(32), strb_t'(rand_bits(4)));
      @(negedge clk);
      check_word("led", word_t'(rec_data_m[15:0]), word_t'(led));
      // one full scan, address digits sit at 4 to 6
      for (int c = 0; c < DIGITS * SCAN_DIV; c++) begin
        d = digit_of_an(an);
        if (d >= 4 && d <= 6) begin
          nib = nibble_t'(rec_addr_m >> (NIBBLE_W * (d - 4)));
          check_word("sev_out", word_t'(seg_decode(nib)), word_t'(sev_out));
        end
        @(negedge clk);
      end
    end
  endtask

  task automatic run_probe(input int count);
    word_t drv_core;
    logic  drv_debug;
    @(posedge clk);
    prog <= 1'b0;
    drv_core    = core_word;
    drv_debug   = debug;
    probe_model = '0;
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      // the DUT has just taken what was driven one edge earlier
      if (!drv_debug) begin
        probe_model = drv_core;
      end
      drv_core  = rand_bits(32);
      drv_debug = (i >= 20 && i < 35) || (i >= 45 && rand_bits(1) != 0);
      core_word <= drv_core;
      debug     <= drv_debug;
      @(negedge clk);
      check_word("led", word_t'(probe_model[15:0]), word_t'(led));
    end
  endtask

  task automatic run_scan(input int periods);
    word_t shown;
    an_t   prev_an;
    an_t   an_exp;
    int    idx;
    int    waited;
    @(posedge clk);
    shown = rand_bits(32);
    prog      <= 1'b0;
    debug     <= 1'b0;
    core_word <= shown;
    @(posedge clk);
    @(negedge clk);
    prev_an = an;
    waited  = 0;
    @(negedge clk);
    // line up on the first cycle of a digit
    while (an == prev_an) begin
      waited++;
      if (waited > DIGITS * SCAN_DIV) begin
        $display("timeout: an never moved on to the next digit");
        report_fail();
      end
      @(negedge clk);
    end
    idx = digit_of_an(an);
    assert (idx >= 0) else begin
      $display("an does not have exactly one low bit");
      report_fail();
    end
    // digit 0 is fe, each later digit one rotation further
    an_exp = 8'hfe;
    for (int k = 0; k < idx; k++) begin
      an_exp = {an_exp[DIGITS-2:0], an_exp[DIGITS-1]};
    end
    for (int p = 0; p < periods; p++) begin
      for (int c = 0; c < SCAN_DIV; c++) begin
        check_word("an", word_t'(an_exp), word_t'(an));
        check_word("sev_out", word_t'(seg_decode(nibble_of(shown, idx))), word_t'(sev_out));
        @(negedge clk);
      end
      idx    = (idx + 1) % DIGITS;
      an_exp = {an_exp[DIGITS-2:0], an_exp[DIGITS-1]};
    end
  endtask

  initial begin
    int waited;
    lfsr_state = 32'h009c_f487;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    debug     = 1'b0;
    prog      = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    core_word = '0;
    pstrb     = '0;
    waited    = 0;
    @(negedge clk);
    while (reset) begin
      waited++;
      if (waited > 10) begin
        $display("timeout: reset was never released");
        report_fail();
      end
      @(negedge clk);
    end
    check_word("an", word_t'(8'hfe), word_t'(an));
    check_word("led", word_t'(0), word_t'(led));
    check_word("pslverr", word_t'(0), word_t'(pslverr));

    // whole memory gets a known pattern first
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_access(1'b1, {widx_t'(i), 2'b00},
                 {6'h15, widx_t'(i), 6'h2a, ~widx_t'(i)}, 4'hf);
    end
    run_memory_mix(200);
    run_error_cases(8);
    run_record_view(20);
    run_probe(60);
    run_scan(40);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/panel_pkg.sv
verilog/mem_apb.sv
verilog/dbg_probe.sv
verilog/panel_mux.sv
verilog/seg_scan.sv
verilog/panel_top.sv
bench/clk_gen.sv
bench/panel_tb.sv

//--- run.sh
#!/bin/sh
# build the debug panel testbench with Verilator and run it
rm -rf obj_dir sim.log build.log

verilator --binary --assert -j 0 -f sim.f --top-module panel_tb -o panel_sim \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/panel_sim > sim.log 2>&1 ; cat sim.log

grep -q "Verification failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
